// ==== char_macros.svh ====
// character game constants
`ifndef CHAR_MACROS_SVH
`define CHAR_MACROS_SVH

// ------------------------------
// map
// ------------------------------
`define CHAR_PHY_WIDTH     15      // signed coordinate width
`define CHAR_SMOOTH        7       // velocity is position << 7
`define CHAR_WALL_WIDTH    10
`define CHAR_LEFT_WALL     590     // inner x of the left wall, +x points left
`define CHAR_RIGHT_WALL    120     // right limit is wall + thickness
`define CHAR_FLOOR         10      // lowest legal y

// character geometry and motion
`define CHAR_SIZE_X        32
`define CHAR_SIZE_Y        32
`define CHAR_INIT_X        286
`define CHAR_INIT_Y        10
`define CHAR_STEP_X        3       // walk step per tick
`define CHAR_GRAVITY       128     // per airborne tick
`define CHAR_MAX_VEL       5120    // symmetric clamp
`define CHAR_JUMP_VEL_X    256
`define CHAR_JUMP_VEL_Y    640
`define CHAR_MAX_CHARGE    100
`define CHAR_CHARGE_STEP   5

// obstacles
`define CHAR_OB_NUM        3       // id value OB_NUM means no hit
`define CHAR_OB_UNIT       10      // block edge length
`define CHAR_OB_LEN_WIDTH  4

`endif

// ==== char_pkg.sv ====
// character game types
`default_nettype none
`include "char_macros.svh"

package char_pkg;

    typedef logic signed [`CHAR_PHY_WIDTH-1:0] coord_t;     // position or velocity
    typedef logic [`CHAR_PHY_WIDTH-2:0]        ob_coord_t;  // unsigned block corner
    typedef logic [1:0]                        ob_id_t;     // 3 means none

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LEFT      = 3'd1,
        RIGHT     = 3'd2,
        CHARGE    = 3'd3,
        JUMP      = 3'd4,
        COLLISION = 3'd5
    } move_state_e;

    typedef enum logic [1:0] {
        HIT_NONE       = 2'd0,
        HIT_VERTICAL   = 2'd1,
        HIT_HORIZONTAL = 2'd2
    } hit_kind_e;

endpackage

`default_nettype wire

// ==== button_edge.sv ====
// button sampling and edge detect
`default_nettype none

module button_edge (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  left_btn,
    input  wire  right_btn,
    input  wire  jump_btn,
    output logic left_lvl,     // one cycle behind the pins
    output logic right_lvl,
    output logic jump_lvl,
    output logic jump_rise
);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_lvl  <= 1'b0;
            right_lvl <= 1'b0;
            jump_lvl  <= 1'b0;
        end else begin
            left_lvl  <= left_btn;
            right_lvl <= right_btn;
            jump_lvl  <= jump_btn;
        end
    end

    // high for the first cycle of a press
    assign jump_rise = jump_btn & ~jump_lvl;

endmodule

`default_nettype wire

// ==== obstacle_probe.sv ====
// obstacle corner probe
`default_nettype none
`include "char_macros.svh"

module obstacle_probe (
    input  wire char_pkg::coord_t    pos_x,
    input  wire char_pkg::coord_t    pos_y,
    input  wire char_pkg::ob_coord_t ob_x   [`CHAR_OB_NUM],
    input  wire char_pkg::ob_coord_t ob_y   [`CHAR_OB_NUM],
    input  wire [`CHAR_OB_LEN_WIDTH-1:0] ob_len [`CHAR_OB_NUM],
    output char_pkg::ob_id_t ob_hit_id,
    output logic             ob_below
);
    import char_pkg::*;

    coord_t x_r;        // right edge column
    coord_t y_t;        // top row
    coord_t y_u;        // row just under the feet

    logic [`CHAR_OB_NUM-1:0] blk_hit;
    logic [`CHAR_OB_NUM-1:0] blk_under;

    assign x_r = pos_x + coord_t'(`CHAR_SIZE_X - 1);
    assign y_t = pos_y + coord_t'(`CHAR_SIZE_Y - 1);
    assign y_u = pos_y - coord_t'(1);

    // ------------------------------
    // per block containment
    // ------------------------------
    // blocks are rectangles, so a corner lies inside when its column
    // and its row both overlap
    for (genvar k = 0; k < `CHAR_OB_NUM; k++) begin : g_blk
        coord_t x0;
        coord_t x1;     // exclusive
        coord_t y0;
        coord_t y1;     // exclusive
        logic   col_l;
        logic   col_r;
        logic   row_b;
        logic   row_t;
        logic   row_u;

        assign x0 = coord_t'({1'b0, ob_x[k]});
        assign x1 = x0 + coord_t'(ob_len[k]) * coord_t'(`CHAR_OB_UNIT);
        assign y0 = coord_t'({1'b0, ob_y[k]});
        assign y1 = y0 + coord_t'(`CHAR_OB_UNIT);

        assign col_l = (pos_x >= x0) && (pos_x < x1);
        assign col_r = (x_r >= x0) && (x_r < x1);
        assign row_b = (pos_y >= y0) && (pos_y < y1);
        assign row_t = (y_t >= y0) && (y_t < y1);
        assign row_u = (y_u >= y0) && (y_u < y1);

        assign blk_hit[k]   = (col_l | col_r) & (row_b | row_t);
        assign blk_under[k] = (col_l | col_r) & row_u;
    end

    // highest index wins
    always_comb begin
        ob_hit_id = ob_id_t'(`CHAR_OB_NUM);
        for (int k = 0; k < `CHAR_OB_NUM; k++) begin
            if (blk_hit[k]) begin
                ob_hit_id = ob_id_t'(k);
            end
        end
    end

    assign ob_below = |blk_under;  // standing on any block

endmodule

`default_nettype wire

// ==== collision_classifier.sv ====
// collision classifier
`default_nettype none
`include "char_macros.svh"

module collision_classifier (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  char_pkg::coord_t    pos_x,
    input  wire  char_pkg::coord_t    pos_y,
    input  wire  char_pkg::coord_t    prev_x,
    input  wire  char_pkg::ob_id_t    ob_hit_id,
    input  wire                       ob_below,
    input  wire  char_pkg::ob_coord_t ob_x   [`CHAR_OB_NUM],
    input  wire  [`CHAR_OB_LEN_WIDTH-1:0] ob_len [`CHAR_OB_NUM],
    output char_pkg::hit_kind_e hit_kind,
    output logic                on_ground
);
    import char_pkg::*;

    coord_t    x_r;
    coord_t    prev_r;      // right edge one step ago
    logic      wall_h;
    logic      wall_v;
    logic [`CHAR_OB_NUM-1:0] side_entry;
    hit_kind_e hit_now;
    hit_kind_e hit_d;
    logic      gnd_now;
    logic      gnd_d;

    assign x_r    = pos_x + coord_t'(`CHAR_SIZE_X - 1);
    assign prev_r = prev_x + coord_t'(`CHAR_SIZE_X - 1);

    // ------------------------------
    // walls
    // ------------------------------
    assign wall_h = (x_r >= coord_t'(`CHAR_LEFT_WALL)) ||
                    (pos_x < coord_t'(`CHAR_RIGHT_WALL + `CHAR_WALL_WIDTH));
    assign wall_v = pos_y < coord_t'(`CHAR_FLOOR);

    // was the character clear of block k in x before this step
    for (genvar k = 0; k < `CHAR_OB_NUM; k++) begin : g_side
        coord_t x0;
        coord_t x1;

        assign x0 = coord_t'({1'b0, ob_x[k]});
        assign x1 = x0 + coord_t'(ob_len[k]) * coord_t'(`CHAR_OB_UNIT);
        assign side_entry[k] = (prev_x >= x1) || (prev_r < x0);
    end

    always_comb begin
        hit_now = HIT_NONE;
        if (wall_h) begin
            hit_now = HIT_HORIZONTAL;
        end else if (wall_v) begin
            hit_now = HIT_VERTICAL;
        end else begin
            for (int k = 0; k < `CHAR_OB_NUM; k++) begin
                if (ob_hit_id == ob_id_t'(k)) begin
                    hit_now = side_entry[k] ? HIT_HORIZONTAL : HIT_VERTICAL;
                end
            end
        end
    end

    assign gnd_now = (pos_y == coord_t'(`CHAR_FLOOR)) || ob_below;

    // two stages, results trail the position by two cycles
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hit_d     <= HIT_NONE;
            gnd_d     <= 1'b0;
            hit_kind  <= HIT_NONE;
            on_ground <= 1'b0;
        end else begin
            hit_d     <= hit_now;
            gnd_d     <= gnd_now;
            hit_kind  <= hit_d;
            on_ground <= gnd_d;
        end
    end

    a_hit_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        hit_kind inside {HIT_NONE, HIT_VERTICAL, HIT_HORIZONTAL});

endmodule

`default_nettype wire

// ==== motion_fsm.sv ====
// movement state machine
`default_nettype none
`include "char_macros.svh"

module motion_fsm (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  step_en,
    input  wire  left_lvl,
    input  wire  right_lvl,
    input  wire  jump_lvl,
    input  wire  jump_rise,
    input  wire  char_pkg::hit_kind_e hit_kind,
    input  wire  on_ground,
    output char_pkg::move_state_e state,
    output logic signed [1:0]     face,       // +1 left, -1 right
    output logic [6:0]            jump_cnt
);
    import char_pkg::*;

    move_state_e next_state;
    logic        jump_armed;   // press seen on the ground
    logic        max_charge;

    assign max_charge = jump_cnt >= 7'(`CHAR_MAX_CHARGE);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_armed <= 1'b0;
        end else if (jump_rise && on_ground) begin
            jump_armed <= 1'b1;
        end else if (state == JUMP) begin
            jump_armed <= 1'b0;
        end
    end

    // ------------------------------
    // state
    // ------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= IDLE;
        end else if (step_en) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = IDLE;
        if (hit_kind != HIT_NONE) begin
            next_state = COLLISION;
        end else begin
            case (state)
                IDLE, LEFT, RIGHT: begin
                    if (on_ground && left_lvl)        next_state = LEFT;
                    else if (on_ground && right_lvl)  next_state = RIGHT;
                    else if (on_ground && jump_armed) next_state = CHARGE;
                    else                              next_state = IDLE;  // airborne too
                end
                CHARGE: next_state = (!jump_lvl || max_charge) ? JUMP : CHARGE;
                default: next_state = IDLE;          // JUMP, COLLISION
            endcase
        end
    end

    // charge counter, saturates at the first value past the limit
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_cnt <= 7'd1;
        end else if (step_en) begin
            if (state == CHARGE && !max_charge) begin
                jump_cnt <= jump_cnt + 7'(`CHAR_CHARGE_STEP);
            end else if (state == JUMP) begin
                jump_cnt <= 7'd1;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= 2'sd1;
        end else if (step_en) begin
            if (hit_kind == HIT_HORIZONTAL) face <= -face;  // bounce off
            else if (state == LEFT)         face <= 2'sd1;
            else if (state == RIGHT)        face <= -2'sd1;
        end
    end

    a_charge_cap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        jump_cnt <= 7'd105);

endmodule

`default_nettype wire

// ==== kinematics.sv ====
// velocity and position integration
`default_nettype none
`include "char_macros.svh"

module kinematics (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  step_en,
    input  wire  char_pkg::move_state_e state,
    input  wire  signed [1:0]           face,
    input  wire  [6:0]                  jump_cnt,
    input  wire  char_pkg::hit_kind_e   hit_kind,
    input  wire  on_ground,
    output char_pkg::coord_t pos_x,
    output char_pkg::coord_t pos_y,
    output char_pkg::coord_t prev_x,
    output char_pkg::coord_t vel_x,
    output char_pkg::coord_t vel_y
);
    import char_pkg::*;

    coord_t jump_f;          // charge-dependent boost
    coord_t imp_x;
    coord_t imp_y;
    coord_t grav_y;
    coord_t vel_x_nxt;
    coord_t vel_y_nxt;
    coord_t walk_x;
    coord_t clamp_x;
    coord_t clamp_y;

    function automatic coord_t clamp_vel(input coord_t v);
        if (v >= coord_t'(`CHAR_MAX_VEL)) begin
            clamp_vel = coord_t'(`CHAR_MAX_VEL);
        end else if (v < -coord_t'(`CHAR_MAX_VEL)) begin
            clamp_vel = -coord_t'(`CHAR_MAX_VEL);
        end else begin
            clamp_vel = v;
        end
    endfunction

    // ------------------------------
    // velocity
    // ------------------------------
    // base boost equals the x launch speed, count bits add coarse to fine
    assign jump_f = coord_t'(`CHAR_JUMP_VEL_X) + coord_t'({jump_cnt[6:4], 8'b0})
                  + coord_t'({jump_cnt[3:2], 7'b0}) + coord_t'({jump_cnt[1:0], 6'b0});

    always_comb begin
        imp_x = '0;
        imp_y = '0;
        if (hit_kind == HIT_VERTICAL) begin
            imp_y = -(vel_y <<< 1);               // reflect
        end else if (hit_kind == HIT_HORIZONTAL) begin
            imp_x = -(vel_x <<< 1);
        end else if (state == JUMP) begin
            imp_x = coord_t'(face) * ((coord_t'(`CHAR_JUMP_VEL_X) + jump_f) >>> 1);
            imp_y = coord_t'(`CHAR_JUMP_VEL_Y) + jump_f;
        end
    end

    assign grav_y = on_ground ? '0 : -coord_t'(`CHAR_GRAVITY);

    // sums stay inside 15 bits since the old velocity is already clamped
    assign vel_x_nxt = clamp_vel(vel_x + imp_x);
    assign vel_y_nxt = clamp_vel(vel_y + imp_y + grav_y);

    // walking, then wall clamp
    always_comb begin
        walk_x = pos_x;
        if (state == LEFT) begin
            walk_x = pos_x + coord_t'(`CHAR_STEP_X);
        end else if (state == RIGHT) begin
            walk_x = pos_x - coord_t'(`CHAR_STEP_X);
        end

        if (walk_x + coord_t'(`CHAR_SIZE_X - 1) >= coord_t'(`CHAR_LEFT_WALL)) begin
            clamp_x = coord_t'(`CHAR_LEFT_WALL - `CHAR_SIZE_X);
        end else if (walk_x < coord_t'(`CHAR_RIGHT_WALL + `CHAR_WALL_WIDTH)) begin
            clamp_x = coord_t'(`CHAR_RIGHT_WALL + `CHAR_WALL_WIDTH);
        end else begin
            clamp_x = walk_x;
        end

        clamp_y = (pos_y < coord_t'(`CHAR_FLOOR)) ? coord_t'(`CHAR_FLOOR) : pos_y;
    end

    // ------------------------------
    // state registers
    // ------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x  <= '0;
            vel_y  <= '0;
            pos_x  <= coord_t'(`CHAR_INIT_X);
            pos_y  <= coord_t'(`CHAR_INIT_Y);
            prev_x <= coord_t'(`CHAR_INIT_X);
        end else if (step_en) begin
            vel_x  <= vel_x_nxt;
            vel_y  <= vel_y_nxt;
            pos_x  <= clamp_x + (vel_x_nxt >>> `CHAR_SMOOTH);
            pos_y  <= clamp_y + (vel_y_nxt >>> `CHAR_SMOOTH);
            prev_x <= pos_x;      // for side-entry test
        end
    end

    a_vel_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (vel_x <= coord_t'(`CHAR_MAX_VEL)) && (vel_x >= -coord_t'(`CHAR_MAX_VEL)) &&
        (vel_y <= coord_t'(`CHAR_MAX_VEL)) && (vel_y >= -coord_t'(`CHAR_MAX_VEL)));

endmodule

`default_nettype wire

// ==== character_top.sv ====
// platform character top level
`default_nettype none
`include "char_macros.svh"

module character_top (
    input  wire  sys_clk,
    input  wire  sys_rst_n,
    input  wire  step_tick,
    input  wire  left_btn,
    input  wire  right_btn,
    input  wire  jump_btn,
    input  wire  char_pkg::ob_coord_t ob_x   [`CHAR_OB_NUM],
    input  wire  char_pkg::ob_coord_t ob_y   [`CHAR_OB_NUM],
    input  wire  [`CHAR_OB_LEN_WIDTH-1:0] ob_len [`CHAR_OB_NUM],
    output char_pkg::coord_t      pos_x,
    output char_pkg::coord_t      pos_y,
    output char_pkg::coord_t      vel_x,
    output char_pkg::coord_t      vel_y,
    output char_pkg::move_state_e state,
    output logic signed [1:0]     face,
    output logic [6:0]            jump_cnt,
    output char_pkg::hit_kind_e   hit_kind,
    output logic                  on_ground
);
    import char_pkg::*;

    logic   step_en;        // step_tick, one cycle late
    logic   left_lvl;
    logic   right_lvl;
    logic   jump_lvl;
    logic   jump_rise;
    coord_t prev_x;
    ob_id_t ob_hit_id;
    logic   ob_below;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) step_en <= 1'b0;
        else            step_en <= step_tick;
    end

    button_edge u_btn (
        .sys_clk, .sys_rst_n, .left_btn, .right_btn, .jump_btn,
        .left_lvl, .right_lvl, .jump_lvl, .jump_rise
    );

    obstacle_probe u_probe (
        .pos_x, .pos_y, .ob_x, .ob_y, .ob_len, .ob_hit_id, .ob_below
    );

    collision_classifier u_class (
        .sys_clk, .sys_rst_n, .pos_x, .pos_y, .prev_x, .ob_hit_id, .ob_below,
        .ob_x, .ob_len, .hit_kind, .on_ground
    );

    motion_fsm u_fsm (
        .sys_clk, .sys_rst_n, .step_en, .left_lvl, .right_lvl, .jump_lvl, .jump_rise,
        .hit_kind, .on_ground, .state, .face, .jump_cnt
    );

    kinematics u_kin (
        .sys_clk, .sys_rst_n, .step_en, .state, .face, .jump_cnt, .hit_kind, .on_ground,
        .pos_x, .pos_y, .prev_x, .vel_x, .vel_y
    );

endmodule

`default_nettype wire

// ==== tb_character.sv ====
// character testbench
`default_nettype none
`include "char_macros.svh"

module tb_character;
    import char_pkg::*;

    localparam int NUM_COLS    = 20;       // fields per pattern record
    localparam int WAIT_LIMIT  = 64;       // cycles allowed for any single wait
    localparam int RUN_LIMIT   = 200000;   // whole-run cycle guard

    logic                          sys_clk;
    logic                          sys_rst_n;
    logic                          step_tick;
    logic                          left_btn;
    logic                          right_btn;
    logic                          jump_btn;
    ob_coord_t                     ob_x   [`CHAR_OB_NUM];
    ob_coord_t                     ob_y   [`CHAR_OB_NUM];
    logic [`CHAR_OB_LEN_WIDTH-1:0] ob_len [`CHAR_OB_NUM];

    coord_t      pos_x;
    coord_t      pos_y;
    coord_t      vel_x;
    coord_t      vel_y;
    move_state_e state;
    logic signed [1:0] face;
    logic [6:0]  jump_cnt;
    hit_kind_e   hit_kind;
    logic        on_ground;

    int   fd;
    logic launch_next;      // previous record ended in JUMP
    int   launch_face;
    int   launch_cnt;

    character_top dut (
        .sys_clk, .sys_rst_n, .step_tick, .left_btn, .right_btn, .jump_btn,
        .ob_x, .ob_y, .ob_len,
        .pos_x, .pos_y, .vel_x, .vel_y, .state, .face, .jump_cnt,
        .hit_kind, .on_ground
    );

    initial sys_clk = 1'b0;
    always #2 sys_clk = ~sys_clk;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string field, input int got, input int exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, field, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // launch x velocity for a jump charged to cnt
    function automatic int launch_vel_x(input int dir, input int cnt);
        int boost;
        boost = `CHAR_JUMP_VEL_X + 256 * (cnt / 16) + 128 * ((cnt / 4) % 4)
              + 64 * (cnt % 4);
        return dir * ((`CHAR_JUMP_VEL_X + boost) / 2);
    endfunction

    task automatic wait_cycles(input int n);
        int waited;
        waited = 0;
        while (waited < n) begin
            @(posedge sys_clk);
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("cycle wait ran too long");
        end
    endtask

    // on_ground trails the reset position by two cycles
    task automatic wait_ground();
        int waited;
        waited = 0;
        while (on_ground !== 1'b1) begin
            @(posedge sys_clk);
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("on_ground never rose after reset");
        end
    endtask

    // one pulse per step, random spacing of 6 to 9 cycles
    task automatic issue_ticks(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            @(posedge sys_clk);
            step_tick <= 1'b1;
            @(posedge sys_clk);
            step_tick <= 1'b0;
            gap = 6 + int'($urandom % 4);
            wait_cycles(gap);
        end
    endtask

    task automatic run_record(input int v [NUM_COLS]);
        @(posedge sys_clk);
        left_btn  <= v[2][0];
        right_btn <= v[3][0];
        jump_btn  <= v[4][0];
        for (int k = 0; k < `CHAR_OB_NUM; k++) begin
            ob_x[k]   <= ob_coord_t'(v[5 + 3*k]);
            ob_y[k]   <= ob_coord_t'(v[6 + 3*k]);
            ob_len[k] <= v[7 + 3*k][`CHAR_OB_LEN_WIDTH-1:0];
        end
        if (v[0] != 0) begin
            sys_rst_n <= 1'b0;
            wait_cycles(2);
            sys_rst_n <= 1'b1;
            @(negedge sys_clk);
            check("on_ground", int'(on_ground), 0);     // reset value
            wait_ground();
            wait_cycles(2);
        end else begin
            wait_cycles(1);     // let the button registers catch up
        end
        issue_ticks(v[1]);
        wait_cycles(4);
        @(negedge sys_clk);
        if (v[19][0]) check("state", int'(state), v[14]);
        if (v[19][1]) check("face", int'(face), v[15]);
        if (v[19][2]) check("jump_cnt", int'(jump_cnt), v[16]);
        if (v[19][3]) check("pos_x", int'(pos_x), v[17]);
        if (v[19][4]) check("vel_y", int'(vel_y), v[18]);
        if (v[0] != 0) begin
            check("pos_y", int'(pos_y), `CHAR_INIT_Y);
            check("vel_x", int'(vel_x), 0);
            check("hit_kind", int'(hit_kind), int'(HIT_NONE));
            check("on_ground", int'(on_ground), 1);
        end else if (launch_next && v[1] == 1) begin
            check("vel_x", int'(vel_x), launch_vel_x(launch_face, launch_cnt));
        end
        launch_next = (v[19][2:0] == 3'b111) && (v[14] == int'(JUMP));
        launch_face = v[15];
        launch_cnt  = v[16];
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        string line;
        int    r;
        int    v [NUM_COLS];

        void'($urandom(8748));
        launch_next = 1'b0;
        launch_face = 0;
        launch_cnt  = 0;
        sys_rst_n   = 1'b0;
        step_tick   = 1'b0;
        left_btn    = 1'b0;
        right_btn   = 1'b0;
        jump_btn    = 1'b0;
        for (int k = 0; k < `CHAR_OB_NUM; k++) begin
            ob_x[k]   = '0;
            ob_y[k]   = '0;
            ob_len[k] = '0;
        end
        wait_cycles(2);
        sys_rst_n <= 1'b1;

        fd = $fopen("character_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file character_patterns.txt");
            $display("Errors found");
            $fatal(1);
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;
                r = $sscanf(line,
                    "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
                if (r != NUM_COLS) begin
                    $display("A pattern line has the wrong number of fields: %s", line);
                    $display("Errors found");
                    $fatal(1);
                end
                run_record(v);
            end
            $fclose(fd);
            $display("No errors");
            $finish;
        end
    end

    // guard against a stuck run
    initial begin
        int n;
        n = 0;
        while (n < RUN_LIMIT) begin
            @(posedge sys_clk);
            n++;
        end
        $display("The simulation ran past its cycle limit");
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== character_patterns.txt ====
# rst ticks left right jump ob0_x ob0_y ob0_len ob1_x ob1_y ob1_len ob2_x ob2_y ob2_len
# exp_state exp_face exp_jump_cnt exp_pos_x exp_vel_y mask(b0 state b1 face b2 cnt b3 x b4 vy)
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 286 0 31
0 1 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 286 0 31
0 10 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 316 0 31
0 90 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 558 0 31
0 2 0 1 0 0 0 0 0 0 0 0 0 0 2 -1 1 555 0 31
0 150 0 1 0 0 0 0 0 0 0 0 0 0 2 -1 1 130 0 31
0 51 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 280 0 31
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 283 0 31
0 1 0 0 1 0 0 0 0 0 0 0 0 0 3 1 1 283 0 31
0 3 0 0 1 0 0 0 0 0 0 0 0 0 3 1 16 283 0 31
0 1 0 0 0 0 0 0 0 0 0 0 0 0 4 1 21 283 0 31
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 286 1344 31
0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 289 1216 31
0 9 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 316 64 31
0 10 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 346 -1216 31
1 0 0 0 0 400 10 3 0 0 0 0 0 0 0 1 1 286 0 31
0 29 1 0 0 400 10 3 0 0 0 0 0 0 1 1 1 370 0 31
0 1 1 0 0 400 10 3 0 0 0 0 0 0 5 -1 1 373 0 31
0 1 0 0 0 400 10 3 0 0 0 0 0 0 5 -1 1 373 0 31
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 286 0 31
0 21 0 0 1 0 0 0 0 0 0 0 0 0 3 1 101 286 0 31
0 1 0 0 1 0 0 0 0 0 0 0 0 0 4 1 101 286 0 31
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 294 2624 31

// ==== compile.f ====
+incdir+.
char_pkg.sv
button_edge.sv
obstacle_probe.sv
collision_classifier.sv
motion_fsm.sv
kinematics.sv
character_top.sv
tb_character.sv

// ==== Bender.yml ====
package:
  name: character

sources:
  - include_dirs:
      - .
    files:
      - char_pkg.sv
      - button_edge.sv
      - obstacle_probe.sv
      - collision_classifier.sv
      - motion_fsm.sv
      - kinematics.sv
      - character_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_character.sv
